//--- files.f
rtl/oc_pkg.sv
rtl/phys_reg_file.sv
rtl/prf_read_arbiter.sv
rtl/operand_collector.sv
rtl/oc_subsystem.sv
verif/oc_tb.sv

//--- Makefile
# Verilator build and run of the operand collector testbench

VERILATOR ?= verilator
TOP       ?= oc_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Testbench failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/oc_tb.sv
// operand collector testbench
// table-driven rows of A and B operands checked against a register
// model, with LFSR data and a cycle limit
`timescale 1ns/1ps

module oc_tb;

    localparam int OC_ENTRIES = 3;
    localparam int FF_PIPES = 4;
    localparam int RESET_CYCLES = 16;
    localparam int PRELOAD_CYCLES = oc_pkg::PRF_ROWS;
    localparam int NUM_ROWS = 14;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PRELOAD_CYCLES + NUM_ROWS * 20;

    typedef enum logic [1:0] {op_zero, op_reg, op_bus, op_fast} kind_e;

    typedef struct packed {
        kind_e         kind_a;
        kind_e         kind_b;
        oc_pkg::preg_t preg_a;
        oc_pkg::preg_t preg_b;
        logic [1:0]    ff_pipe;
        logic [3:0]    ff_delay;
        logic          hold;
    } row_t;

    // hold rows leave the acks off so the queues fill to OC_ENTRIES
    row_t rows [NUM_ROWS] = '{
        '{op_reg,  op_reg,  6'd5,  6'd12, 2'd0, 4'd0, 1'b0},
        '{op_reg,  op_reg,  6'd7,  6'd9,  2'd0, 4'd0, 1'b0},
        '{op_bus,  op_zero, 6'd10, 6'd0,  2'd0, 4'd0, 1'b0},
        '{op_zero, op_bus,  6'd0,  6'd21, 2'd0, 4'd0, 1'b0},
        '{op_bus,  op_bus,  6'd14, 6'd23, 2'd0, 4'd0, 1'b0},
        '{op_fast, op_reg,  6'd0,  6'd30, 2'd2, 4'd3, 1'b0},
        '{op_zero, op_fast, 6'd0,  6'd0,  2'd1, 4'd0, 1'b0},
        '{op_fast, op_fast, 6'd0,  6'd0,  2'd3, 4'd5, 1'b0},
        '{op_zero, op_zero, 6'd0,  6'd0,  2'd0, 4'd0, 1'b0},
        '{op_reg,  op_bus,  6'd33, 6'd36, 2'd0, 4'd0, 1'b1},
        '{op_bus,  op_reg,  6'd40, 6'd41, 2'd0, 4'd0, 1'b1},
        '{op_reg,  op_zero, 6'd44, 6'd0,  2'd0, 4'd0, 1'b0},
        '{op_zero, op_reg,  6'd0,  6'd10, 2'd0, 4'd0, 1'b0},
        '{op_reg,  op_reg,  6'd14, 6'd23, 2'd0, 4'd0, 1'b0}
    };

    logic CLK = 1'b0;
    logic nRST;
    oc_pkg::oc_enq_t enq_a;
    oc_pkg::oc_enq_t enq_b;
    oc_pkg::writeback_t [oc_pkg::PRF_BANK_COUNT-1:0] writeback_by_bank;
    oc_pkg::fast_forward_t [FF_PIPES-1:0] fast_forward_by_pipe;
    logic operand_notif_valid_a, operand_notif_ack_a, operand_data_ack_a;
    logic operand_notif_valid_b, operand_notif_ack_b, operand_data_ack_b;
    oc_pkg::word_t operand_data_a;
    oc_pkg::word_t operand_data_b;

    // register model and per-side expected operands in enqueue order
    oc_pkg::word_t model_regs [oc_pkg::PRF_ENTRIES];
    oc_pkg::word_t exp_a [$];
    oc_pkg::word_t exp_b [$];
    // head already seen ready and not yet acked
    logic ready_seen_a = 1'b0;
    logic ready_seen_b = 1'b0;
    logic [15:0] lfsr_state = 16'd39;
    int word_errors = 0;
    int bit_errors = 0;
    int cycle_count = 0;

    oc_subsystem #(.OC_ENTRIES(OC_ENTRIES), .FAST_FORWARD_PIPE_COUNT(FF_PIPES)) dut (.*);

    always #4 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles, an operand never came ready",
                TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // ----------------------------------------
    // data source and compares

    // galois form with taps at x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic next_word(output oc_pkg::word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_word(input string name, input oc_pkg::word_t exp,
                              input oc_pkg::word_t act);
        if (act !== exp) begin
            word_errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            bit_errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // a ready head shows its expected data and stays ready until acked
    // an empty side shows no notif
    task automatic check_heads();
        if (exp_a.size() == 0) begin
            check_bit("operand_notif_valid_a", 1'b0, operand_notif_valid_a);
        end else begin
            if (ready_seen_a) begin
                check_bit("operand_notif_valid_a", 1'b1, operand_notif_valid_a);
            end
            if (operand_notif_valid_a) begin
                ready_seen_a = 1'b1;
                check_word("operand_data_a", exp_a[0], operand_data_a);
            end
        end
        if (exp_b.size() == 0) begin
            check_bit("operand_notif_valid_b", 1'b0, operand_notif_valid_b);
        end else begin
            if (ready_seen_b) begin
                check_bit("operand_notif_valid_b", 1'b1, operand_notif_valid_b);
            end
            if (operand_notif_valid_b) begin
                ready_seen_b = 1'b1;
                check_word("operand_data_b", exp_b[0], operand_data_b);
            end
        end
    endtask

    // ----------------------------------------
    // stimulus

    function automatic oc_pkg::oc_enq_t make_enq(input kind_e kind, input oc_pkg::preg_t preg,
                                                 input logic [1:0] pipe);
        return '{valid: 1'b1, is_reg: kind == op_reg, is_bus_forward: kind == op_bus,
            is_fast_forward: kind == op_fast, fast_forward_pipe: pipe, preg: preg};
    endfunction

    // bus operands write their register in the enqueue cycle
    task automatic prepare_side(input kind_e kind, input oc_pkg::preg_t preg,
                                input oc_pkg::word_t ff_value, output oc_pkg::word_t value);
        value = '0;
        case (kind)
            op_reg: value = model_regs[preg];
            op_bus: begin
                next_word(value);
                writeback_by_bank[preg[0]] = '{valid: 1'b1, preg: preg, data: value};
                model_regs[preg] = value;
            end
            op_fast: value = ff_value;
            default: value = '0;
        endcase
    endtask

    // unchosen pipes carry decoy values
    task automatic drive_pipes(input logic [1:0] chosen, input logic fire,
                               input oc_pkg::word_t value);
        oc_pkg::word_t decoy;
        for (int p = 0; p < FF_PIPES; p++) begin
            next_word(decoy);
            if (p == int'(chosen)) begin
                fast_forward_by_pipe[p] = '{valid: fire, data: value};
            end else begin
                fast_forward_by_pipe[p] = '{valid: 1'b1, data: decoy};
            end
        end
    endtask

    task automatic preload_regs();
        oc_pkg::word_t value;
        oc_pkg::preg_t preg;
        for (int row = 0; row < PRELOAD_CYCLES; row++) begin
            @(negedge CLK);
            for (int b = 0; b < oc_pkg::PRF_BANK_COUNT; b++) begin
                next_word(value);
                preg = oc_pkg::preg_t'(row * oc_pkg::PRF_BANK_COUNT + b);
                writeback_by_bank[b] = '{valid: 1'b1, preg: preg, data: value};
                model_regs[preg] = value;
            end
        end
        @(negedge CLK);
        writeback_by_bank = '0;
    endtask

    // ack each side whenever its head is ready, until both queues empty
    task automatic drain();
        logic ack_a;
        logic ack_b;
        while (exp_a.size() > 0 || exp_b.size() > 0) begin
            @(negedge CLK);
            check_heads();
            ack_a = (exp_a.size() > 0) && operand_notif_valid_a;
            ack_b = (exp_b.size() > 0) && operand_notif_valid_b;
            if (ack_a) begin
                exp_a.delete(0);
                ready_seen_a = 1'b0;
            end
            if (ack_b) begin
                exp_b.delete(0);
                ready_seen_b = 1'b0;
            end
            operand_notif_ack_a = ack_a;
            operand_data_ack_a = ack_a;
            operand_notif_ack_b = ack_b;
            operand_data_ack_b = ack_b;
        end
        @(negedge CLK);
        operand_notif_ack_a = 1'b0;
        operand_data_ack_a = 1'b0;
        operand_notif_ack_b = 1'b0;
        operand_data_ack_b = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        oc_pkg::word_t ff_value;
        oc_pkg::word_t value_a;
        oc_pkg::word_t value_b;
        logic fast_row;
        int delay;
        int last;
        fast_row = (r.kind_a == op_fast) || (r.kind_b == op_fast);
        delay = int'(r.ff_delay);
        last = fast_row ? delay + 1 : 0;
        next_word(ff_value);
        @(negedge CLK);
        check_heads();
        enq_a = make_enq(r.kind_a, r.preg_a, r.ff_pipe);
        enq_b = make_enq(r.kind_b, r.preg_b, r.ff_pipe);
        prepare_side(r.kind_a, r.preg_a, ff_value, value_a);
        prepare_side(r.kind_b, r.preg_b, ff_value, value_b);
        exp_a.push_back(value_a);
        exp_b.push_back(value_b);
        for (int d = 0; d <= last; d++) begin
            @(negedge CLK);
            check_heads();
            enq_a = '0;
            enq_b = '0;
            writeback_by_bank = '0;
            fast_forward_by_pipe = '0;
            // fast operands stay unready until their pipe fires
            if (fast_row && d <= delay) begin
                if (r.kind_a == op_fast) begin
                    check_bit("operand_notif_valid_a", 1'b0, operand_notif_valid_a);
                end
                if (r.kind_b == op_fast) begin
                    check_bit("operand_notif_valid_b", 1'b0, operand_notif_valid_b);
                end
                drive_pipes(r.ff_pipe, d == delay, ff_value);
            end
        end
        if (!r.hold) begin
            drain();
        end
    endtask

    initial begin
        nRST = 1'b0;
        enq_a = '0;
        enq_b = '0;
        writeback_by_bank = '0;
        fast_forward_by_pipe = '0;
        operand_notif_ack_a = 1'b0;
        operand_data_ack_a = 1'b0;
        operand_notif_ack_b = 1'b0;
        operand_data_ack_b = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        check_bit("operand_notif_valid_a", 1'b0, operand_notif_valid_a);
        check_bit("operand_notif_valid_b", 1'b0, operand_notif_valid_b);
        preload_regs();
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        @(negedge CLK);
        check_heads();
        $display("error counts: %0d data, %0d notif", word_errors, bit_errors);
        if (word_errors + bit_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- rtl/oc_subsystem.sv
// operand stage top level
// A and B collectors sharing one PRF read port through a
// round-robin arbiter, fed by the banked PRF and fast-forward pipes
`timescale 1ns/1ps

module oc_subsystem #(
    parameter int OC_ENTRIES = 3,
    parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  oc_pkg::oc_enq_t                                     enq_a,
    input  oc_pkg::oc_enq_t                                     enq_b,
    input  oc_pkg::writeback_t [oc_pkg::PRF_BANK_COUNT-1:0]     writeback_by_bank,
    input  oc_pkg::fast_forward_t [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_by_pipe,
    output logic                                                operand_notif_valid_a,
    input  logic                                                operand_notif_ack_a,
    output oc_pkg::word_t                                       operand_data_a,
    input  logic                                                operand_data_ack_a,
    output logic                                                operand_notif_valid_b,
    input  logic                                                operand_notif_ack_b,
    output oc_pkg::word_t                                       operand_data_b,
    input  logic                                                operand_data_ack_b
);

    oc_pkg::reg_read_req_t  req_a, req_b, prf_read_req;
    oc_pkg::reg_read_resp_t resp_a, resp_b, prf_read_resp;
    logic                   grant_a, grant_b;

    oc_pkg::word_t [oc_pkg::PRF_BANK_COUNT-1:0] bus_forward_data_by_bank;

    phys_reg_file u_prf (
        .CLK                      (CLK),
        .nRST                     (nRST),
        .writeback_by_bank        (writeback_by_bank),
        .read_req                 (prf_read_req),
        .read_resp                (prf_read_resp),
        .bus_forward_data_by_bank (bus_forward_data_by_bank)
    );

    prf_read_arbiter u_arb (
        .CLK           (CLK),
        .nRST          (nRST),
        .req_a         (req_a),
        .req_b         (req_b),
        .grant_a       (grant_a),
        .grant_b       (grant_b),
        .prf_read_req  (prf_read_req),
        .prf_read_resp (prf_read_resp),
        .resp_a        (resp_a),
        .resp_b        (resp_b)
    );

    // ----------------------------------------
    // per-operand collectors

    operand_collector #(
        .OC_ENTRIES              (OC_ENTRIES),
        .FAST_FORWARD_PIPE_COUNT (FAST_FORWARD_PIPE_COUNT)
    ) u_oc_a (
        .CLK (CLK), .nRST (nRST), .enq (enq_a),
        .reg_read_req (req_a), .reg_read_grant (grant_a), .reg_read_resp (resp_a),
        .bus_forward_data_by_bank (bus_forward_data_by_bank),
        .fast_forward_by_pipe (fast_forward_by_pipe),
        .operand_notif_valid (operand_notif_valid_a), .operand_notif_ack (operand_notif_ack_a),
        .operand_data (operand_data_a), .operand_data_ack (operand_data_ack_a)
    );

    operand_collector #(
        .OC_ENTRIES              (OC_ENTRIES),
        .FAST_FORWARD_PIPE_COUNT (FAST_FORWARD_PIPE_COUNT)
    ) u_oc_b (
        .CLK (CLK), .nRST (nRST), .enq (enq_b),
        .reg_read_req (req_b), .reg_read_grant (grant_b), .reg_read_resp (resp_b),
        .bus_forward_data_by_bank (bus_forward_data_by_bank),
        .fast_forward_by_pipe (fast_forward_by_pipe),
        .operand_notif_valid (operand_notif_valid_b), .operand_notif_ack (operand_notif_ack_b),
        .operand_data (operand_data_b), .operand_data_ack (operand_data_ack_b)
    );

endmodule

//--- rtl/operand_collector.sv
// operand collector
// circular queue of source operands, each filled by a PRF read,
// a bus forward, a fast forward, or left at zero
`timescale 1ns/1ps

module operand_collector #(
    parameter int OC_ENTRIES = 3,
    parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  oc_pkg::oc_enq_t                               enq,
    output oc_pkg::reg_read_req_t                         reg_read_req,
    input  logic                                          reg_read_grant,
    input  oc_pkg::reg_read_resp_t                        reg_read_resp,
    input  oc_pkg::word_t [oc_pkg::PRF_BANK_COUNT-1:0]    bus_forward_data_by_bank,
    input  oc_pkg::fast_forward_t [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_by_pipe,
    output logic                                          operand_notif_valid,
    input  logic                                          operand_notif_ack,
    output oc_pkg::word_t                                 operand_data,
    input  logic                                          operand_data_ack
);

    localparam int PTR_W = (OC_ENTRIES > 1) ? $clog2(OC_ENTRIES) : 1;

    typedef struct packed {
        logic valid;
        logic need_reg;
        logic reg_in_flight;
        logic need_bus_forward;
        logic need_fast_forward;
    } entry_ctrl_t;

    typedef struct packed {
        logic [oc_pkg::FAST_FORWARD_PIPE_WIDTH-1:0] fast_forward_pipe;
        oc_pkg::preg_t                              preg;
        oc_pkg::word_t                              data;
    } entry_payload_t;

    entry_ctrl_t    [OC_ENTRIES-1:0] ctrl_q;
    entry_payload_t [OC_ENTRIES-1:0] payload_q;

    logic [PTR_W-1:0] enq_ptr, notif_ptr, data_ptr;
    logic [OC_ENTRIES-1:0] wraparound_mask;
    logic [OC_ENTRIES-1:0] need_reg_vec;
    logic [OC_ENTRIES-1:0] reg_pick_vec;
    logic                  reg_sel_found;
    logic [PTR_W-1:0]      reg_sel_idx;

    logic [OC_ENTRIES-1:0]                reg_arrive;
    logic [OC_ENTRIES-1:0]                ff_arrive;
    logic [OC_ENTRIES-1:0]                fill_valid;
    oc_pkg::word_t [OC_ENTRIES-1:0]       fill_data;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(OC_ENTRIES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ----------------------------------------
    // oldest entry waiting on a reg read

    // entries at or past the notif pointer come first
    always_comb begin
        for (int i = 0; i < OC_ENTRIES; i++) begin
            wraparound_mask[i] = PTR_W'(i) >= notif_ptr;
            need_reg_vec[i] = ctrl_q[i].need_reg;
        end
        reg_pick_vec = (|(need_reg_vec & wraparound_mask)) ?
            (need_reg_vec & wraparound_mask) : need_reg_vec;
        reg_sel_found = 1'b0;
        reg_sel_idx = '0;
        for (int i = OC_ENTRIES - 1; i >= 0; i--) begin
            if (reg_pick_vec[i]) begin
                reg_sel_found = 1'b1;
                reg_sel_idx = PTR_W'(i);
            end
        end
    end

    // one read in flight at a time
    assign reg_read_req.valid = reg_sel_found & ~ctrl_q[reg_sel_idx].reg_in_flight;
    assign reg_read_req.preg = payload_q[reg_sel_idx].preg;

    // ----------------------------------------
    // incoming operand data per entry

    always_comb begin
        for (int i = 0; i < OC_ENTRIES; i++) begin
            reg_arrive[i] = ctrl_q[i].reg_in_flight & reg_read_resp.valid;
            ff_arrive[i] = ctrl_q[i].need_fast_forward
                & fast_forward_by_pipe[payload_q[i].fast_forward_pipe].valid;
            fill_valid[i] = reg_arrive[i] | ff_arrive[i] | ctrl_q[i].need_bus_forward;
            fill_data[i] = payload_q[i].data;
            if (reg_arrive[i]) begin
                fill_data[i] = reg_read_resp.data;
            end
            // only ever set on the cycle after enqueue
            if (ctrl_q[i].need_bus_forward) begin
                fill_data[i] =
                    bus_forward_data_by_bank[oc_pkg::preg_bank(payload_q[i].preg)];
            end
            if (ff_arrive[i]) begin
                fill_data[i] = fast_forward_by_pipe[payload_q[i].fast_forward_pipe].data;
            end
        end
    end

    assign operand_notif_valid = ctrl_q[notif_ptr].valid
        & (~ctrl_q[notif_ptr].need_reg | reg_arrive[notif_ptr])
        & (~ctrl_q[notif_ptr].need_fast_forward | ff_arrive[notif_ptr]);

    // bypass so data matches notif on the arrival cycle
    assign operand_data = fill_data[data_ptr];

    // ----------------------------------------
    // entry state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ctrl_q <= '0;
        end else begin
            for (int i = 0; i < OC_ENTRIES; i++) begin
                if (reg_arrive[i]) begin
                    ctrl_q[i].need_reg <= 1'b0;
                    ctrl_q[i].reg_in_flight <= 1'b0;
                end
                ctrl_q[i].need_bus_forward <= 1'b0;
                if (ff_arrive[i]) begin
                    ctrl_q[i].need_fast_forward <= 1'b0;
                end
            end
            if (reg_read_req.valid && reg_read_grant) begin
                ctrl_q[reg_sel_idx].reg_in_flight <= 1'b1;
            end
            if (operand_data_ack) begin
                ctrl_q[data_ptr].valid <= 1'b0;
            end
            if (enq.valid) begin
                ctrl_q[enq_ptr] <= '{valid: 1'b1, need_reg: enq.is_reg, reg_in_flight: 1'b0,
                    need_bus_forward: enq.is_bus_forward,
                    need_fast_forward: enq.is_fast_forward};
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < OC_ENTRIES; i++) begin
            if (fill_valid[i]) begin
                payload_q[i].data <= fill_data[i];
            end
        end
        if (enq.valid) begin
            // zero operand keeps this value
            payload_q[enq_ptr].data <= '0;
            payload_q[enq_ptr].preg <= enq.preg;
            payload_q[enq_ptr].fast_forward_pipe <= enq.fast_forward_pipe;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr <= '0;
            notif_ptr <= '0;
            data_ptr <= '0;
        end else begin
            if (enq.valid) begin
                enq_ptr <= ptr_inc(enq_ptr);
            end
            if (operand_notif_ack) begin
                notif_ptr <= ptr_inc(notif_ptr);
            end
            if (operand_data_ack) begin
                data_ptr <= ptr_inc(data_ptr);
            end
        end
    end

    a_no_enq_when_full: assert property (@(posedge CLK) disable iff (!nRST)
        enq.valid |-> !ctrl_q[enq_ptr].valid);

    a_data_ack_valid: assert property (@(posedge CLK) disable iff (!nRST)
        operand_data_ack |-> ctrl_q[data_ptr].valid);

endmodule

//--- rtl/prf_read_arbiter.sv
// PRF read arbiter
// round-robin grant of the single read port between the A and B
// collectors, with each response steered back to last cycle's winner
`timescale 1ns/1ps

module prf_read_arbiter (
    input  logic                   CLK,
    input  logic                   nRST,
    input  oc_pkg::reg_read_req_t  req_a,
    input  oc_pkg::reg_read_req_t  req_b,
    output logic                   grant_a,
    output logic                   grant_b,
    output oc_pkg::reg_read_req_t  prf_read_req,
    input  oc_pkg::reg_read_resp_t prf_read_resp,
    output oc_pkg::reg_read_resp_t resp_a,
    output oc_pkg::reg_read_resp_t resp_b
);

    // high when B wins a tie
    logic prio_b_q;
    // owner of the read in flight to the PRF
    logic owner_b_q;

    assign grant_a = req_a.valid & (~req_b.valid | ~prio_b_q);
    assign grant_b = req_b.valid & (~req_a.valid | prio_b_q);

    assign prf_read_req.valid = grant_a | grant_b;
    assign prf_read_req.preg = grant_b ? req_b.preg : req_a.preg;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            prio_b_q <= 1'b0;
            owner_b_q <= 1'b0;
        end else begin
            // flip after every grant
            if (grant_a | grant_b) begin
                prio_b_q <= grant_a;
            end
            owner_b_q <= grant_b;
        end
    end

    assign resp_a.valid = prf_read_resp.valid & ~owner_b_q;
    assign resp_a.data = prf_read_resp.data;
    assign resp_b.valid = prf_read_resp.valid & owner_b_q;
    assign resp_b.data = prf_read_resp.data;

    // a peer left waiting wins the next grant
    a_rr_wait_a: assert property (@(posedge CLK) disable iff (!nRST)
        (grant_b && req_a.valid) |=> grant_a);

    a_rr_wait_b: assert property (@(posedge CLK) disable iff (!nRST)
        (grant_a && req_b.valid) |=> grant_b);

endmodule

//--- rtl/phys_reg_file.sv
// physical register file
// two banks, each with its own writeback port, one registered read
// port and a per-bank register of the last written value
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  oc_pkg::writeback_t [oc_pkg::PRF_BANK_COUNT-1:0] writeback_by_bank,
    input  oc_pkg::reg_read_req_t                           read_req,
    output oc_pkg::reg_read_resp_t                          read_resp,
    output oc_pkg::word_t [oc_pkg::PRF_BANK_COUNT-1:0]      bus_forward_data_by_bank
);

    // ----------------------------------------
    // storage

    oc_pkg::word_t bank_mem [oc_pkg::PRF_BANK_COUNT][oc_pkg::PRF_ROWS];

    oc_pkg::word_t [oc_pkg::PRF_BANK_COUNT-1:0] bus_forward_q;
    logic                                       resp_valid_q;
    oc_pkg::word_t                              resp_data_q;

    // one write per bank per cycle, tag bank must match the port
    always_ff @(posedge CLK) begin
        for (int b = 0; b < oc_pkg::PRF_BANK_COUNT; b++) begin
            if (writeback_by_bank[b].valid) begin
                bank_mem[b][oc_pkg::preg_row(writeback_by_bank[b].preg)] <=
                    writeback_by_bank[b].data;
                bus_forward_q[b] <= writeback_by_bank[b].data;
            end
        end
    end

    // ----------------------------------------
    // read port

    // same-edge write is not seen, read returns the old value
    always_ff @(posedge CLK) begin
        if (read_req.valid) begin
            resp_data_q <= bank_mem[oc_pkg::preg_bank(read_req.preg)]
                                   [oc_pkg::preg_row(read_req.preg)];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= read_req.valid;
        end
    end

    assign read_resp.valid = resp_valid_q;
    assign read_resp.data = resp_data_q;
    assign bus_forward_data_by_bank = bus_forward_q;

    // writeback tags arrive on the port of their own bank
    for (genvar b = 0; b < oc_pkg::PRF_BANK_COUNT; b++) begin : g_wb_check
        a_wb_bank_match: assert property (@(posedge CLK) disable iff (!nRST)
            writeback_by_bank[b].valid |->
                oc_pkg::preg_bank(writeback_by_bank[b].preg) ==
                    oc_pkg::LOG_PRF_BANK_COUNT'(b));
    end

endmodule

//--- rtl/oc_pkg.sv
// operand collector package
// widths, register tag helpers and the structs shared by the
// register file, the read arbiter and the collectors

package oc_pkg;

    localparam int PRF_BANK_COUNT = 2;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);
    localparam int PRF_ENTRIES = 64;
    localparam int LOG_PRF_ENTRIES = $clog2(PRF_ENTRIES);
    localparam int PRF_ROWS = PRF_ENTRIES / PRF_BANK_COUNT;
    localparam int LOG_PRF_ROWS = $clog2(PRF_ROWS);
    // pipe select field, room for up to 4 fast-forward pipes
    localparam int FAST_FORWARD_PIPE_WIDTH = 2;

    typedef logic [31:0] word_t;
    // low bits pick the bank, upper bits the row
    typedef logic [LOG_PRF_ENTRIES-1:0] preg_t;

    typedef struct packed {
        logic                               valid;
        logic                               is_reg;
        logic                               is_bus_forward;
        logic                               is_fast_forward;
        logic [FAST_FORWARD_PIPE_WIDTH-1:0] fast_forward_pipe;
        preg_t                              preg;
    } oc_enq_t;

    typedef struct packed { logic valid; preg_t preg; } reg_read_req_t;
    typedef struct packed { logic valid; word_t data; } reg_read_resp_t;
    typedef struct packed { logic valid; preg_t preg; word_t data; } writeback_t;
    typedef struct packed { logic valid; word_t data; } fast_forward_t;

    function automatic logic [LOG_PRF_BANK_COUNT-1:0] preg_bank(input preg_t preg);
        return preg[LOG_PRF_BANK_COUNT-1:0];
    endfunction

    function automatic logic [LOG_PRF_ROWS-1:0] preg_row(input preg_t preg);
        return preg[LOG_PRF_ENTRIES-1:LOG_PRF_BANK_COUNT];
    endfunction

endpackage
